//--- Makefile
VERILATOR  = verilator
FILELIST   = tb.f
TOP        = uart_core_tb
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/uart_core_checker.sv
`timescale 1ns/1ns
`default_nettype none

module uart_core_checker (
    input wire                      clk,
    input wire                      rst_n,
    input wire                      req,
    input wire                      ack,
    input wire                      tx,
    input wire uart_pkg::tx_state_e tx_state
);

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose without a pending req");

    // ack may only drop once the host has released req.
    ack_held: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    idle_line: assert property (@(posedge clk) disable iff (!rst_n)
        tx_state == uart_pkg::tx_idle |-> tx)
        else $error("tx is low while the serializer is idle");

endmodule

bind uart_core uart_core_checker checker_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .ack     (ack),
    .tx      (tx),
    .tx_state(tx_path_i.state)
);

`default_nettype wire

//--- bench/uart_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module uart_core_tb;

    localparam int clks_per_bit = 8;
    localparam int fifo_depth   = 4;
    localparam int max_cycles   = 20 * 10 * clks_per_bit + 2000;

    logic                        clk;
    logic                        rst_n;
    logic                        req;
    logic                        we;
    uart_pkg::reg_addr_e         addr;
    logic [uart_pkg::data_w-1:0] wdata;
    logic                        ack;
    logic [uart_pkg::data_w-1:0] rdata;
    logic                        tx;
    logic                        rx;
    int                          errors = 0;
    int                          cycles = 0;
    int                          seed   = 32'h1dc7;

    uart_core #(
        .clks_per_bit(clks_per_bit),
        .fifo_depth  (fifo_depth)
    ) dut_i (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (req),
        .we   (we),
        .addr (addr),
        .wdata(wdata),
        .ack  (ack),
        .rdata(rdata),
        .tx   (tx),
        .rx   (rx)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("sim failed");
            $finish;
        end
    end

    function automatic uart_pkg::uart_status_t make_status(input logic frame_err,
            input logic overflow, input logic avail, input logic full, input logic busy);
        uart_pkg::uart_status_t s;
        s.frame_err   = frame_err;
        s.rx_overflow = overflow;
        s.rx_avail    = avail;
        s.tx_full     = full;
        s.tx_busy     = busy;
        return s;
    endfunction

    task automatic check_byte(input logic [uart_pkg::data_w-1:0] got,
                              input logic [uart_pkg::data_w-1:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t ns: %s is 8'h%02h, expected 8'h%02h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_status(input uart_pkg::uart_status_t got,
                                input uart_pkg::uart_status_t exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t ns: %s is %05b, expected %05b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_line(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // every task starts and ends 1 ns after a rising edge.
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic host_access(input logic wr, input uart_pkg::reg_addr_e a,
                               input logic [uart_pkg::data_w-1:0] wd,
                               output logic [uart_pkg::data_w-1:0] rd);
        req   = 1'b1;
        we    = wr;
        addr  = a;
        wdata = wd;
        next_cycle();
        while (!ack) begin
            next_cycle();
        end
        rd  = rdata;
        req = 1'b0;
        while (ack) begin
            next_cycle();
        end
    endtask

    task automatic host_write(input uart_pkg::reg_addr_e a,
                              input logic [uart_pkg::data_w-1:0] d);
        logic [uart_pkg::data_w-1:0] unused;
        host_access(1'b1, a, d, unused);
    endtask

    task automatic host_read(input uart_pkg::reg_addr_e a,
                             output logic [uart_pkg::data_w-1:0] d);
        host_access(1'b0, a, '0, d);
    endtask

    task automatic read_status(output uart_pkg::uart_status_t st);
        logic [uart_pkg::data_w-1:0] rd;
        host_read(uart_pkg::addr_status, rd);
        check_byte(rd >> $bits(uart_pkg::uart_status_t), '0, "unused status bits");
        st = rd[$bits(uart_pkg::uart_status_t)-1:0];
    endtask

    task automatic wait_rx_avail(output uart_pkg::uart_status_t st);
        int tries = 0;
        read_status(st);
        while (!st.rx_avail && tries < 40) begin
            read_status(st);
            tries++;
        end
        if (!st.rx_avail) begin
            $display("no received byte became available at %0t ns", $time);
            errors++;
        end
    endtask

    task automatic drive_bit(input logic v);
        rx = v;
        wait_cycles(clks_per_bit);
    endtask

    task automatic send_frame(input logic [uart_pkg::data_w-1:0] b, input logic bad_stop);
        drive_bit(1'b0);
        for (int i = 0; i < uart_pkg::data_w; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(!bad_stop);
        if (bad_stop) begin
            drive_bit(1'b1);  // an idle bit so the next start edge can be seen.
        end
    endtask

    // returns at the middle of the stop bit.
    task automatic capture_frame(output logic [uart_pkg::data_w-1:0] b, output logic stop);
        while (tx !== 1'b0) begin
            next_cycle();
        end
        wait_cycles(clks_per_bit / 2);
        check_line(tx, 1'b0, "tx start bit");
        for (int i = 0; i < uart_pkg::data_w; i++) begin
            wait_cycles(clks_per_bit);
            b[i] = tx;
        end
        wait_cycles(clks_per_bit);
        stop = tx;
    endtask

    task automatic after_reset();
        uart_pkg::uart_status_t st;
        check_line(ack, 1'b0, "ack after reset");
        check_byte(rdata, '0, "rdata after reset");
        read_status(st);
        check_status(st, make_status(0, 0, 0, 0, 0), "status after reset");
        for (int i = 0; i < 2 * clks_per_bit; i++) begin
            check_line(tx, 1'b1, "tx after reset");
            next_cycle();
        end
    endtask

    task automatic single_byte_out();
        logic [uart_pkg::data_w-1:0] b;
        logic [uart_pkg::data_w-1:0] got;
        logic                        stop;
        uart_pkg::uart_status_t      st;
        b = 8'($random(seed));
        fork
            capture_frame(got, stop);
            begin
                host_write(uart_pkg::addr_data, b);
                read_status(st);
                check_status(st, make_status(0, 0, 0, 0, 1), "status during frame");
            end
        join
        check_byte(got, b, "tx byte");
        check_line(stop, 1'b1, "tx stop bit");
        wait_cycles(clks_per_bit);
        read_status(st);
        check_status(st, make_status(0, 0, 0, 0, 0), "status after frame");
    endtask

    // the first byte moves straight into the serializer, the next ones fill the FIFO.
    task automatic burst_out();
        logic [uart_pkg::data_w-1:0] sent [fifo_depth + 1];
        logic [uart_pkg::data_w-1:0] got;
        logic                        stop;
        uart_pkg::uart_status_t      st;
        for (int i = 0; i < fifo_depth + 1; i++) begin
            sent[i] = 8'($random(seed));
        end
        fork
            for (int i = 0; i < fifo_depth + 1; i++) begin
                capture_frame(got, stop);
                check_byte(got, sent[i], "burst byte");
                check_line(stop, 1'b1, "burst stop bit");
            end
            begin
                for (int i = 0; i < fifo_depth + 1; i++) begin
                    host_write(uart_pkg::addr_data, sent[i]);
                end
                read_status(st);
                check_status(st, make_status(0, 0, 0, 1, 1), "status with tx fifo full");
                host_write(uart_pkg::addr_data, ~sent[0]);
            end
        join
        wait_cycles(clks_per_bit);
        read_status(st);
        check_status(st, make_status(0, 0, 0, 0, 0), "status after burst");
    endtask

    task automatic bytes_in();
        logic [uart_pkg::data_w-1:0] sent [3];
        logic [uart_pkg::data_w-1:0] got;
        uart_pkg::uart_status_t      st;
        for (int i = 0; i < 3; i++) begin
            sent[i] = 8'($random(seed));
            send_frame(sent[i], 1'b0);
        end
        wait_rx_avail(st);
        check_status(st, make_status(0, 0, 1, 0, 0), "status with received bytes");
        for (int i = 0; i < 3; i++) begin
            host_read(uart_pkg::addr_data, got);
            check_byte(got, sent[i], "received byte");
        end
        host_read(uart_pkg::addr_data, got);
        check_byte(got, '0, "read from empty rx fifo");
    endtask

    task automatic overflow_in();
        logic [uart_pkg::data_w-1:0] sent [fifo_depth + 1];
        logic [uart_pkg::data_w-1:0] got;
        uart_pkg::uart_status_t      st;
        for (int i = 0; i < fifo_depth + 1; i++) begin
            sent[i] = 8'($random(seed));
            send_frame(sent[i], 1'b0);
        end
        read_status(st);
        check_status(st, make_status(0, 1, 1, 0, 0), "status after overflow");
        read_status(st);
        check_status(st, make_status(0, 0, 1, 0, 0), "status after clear");
        for (int i = 0; i < fifo_depth; i++) begin
            host_read(uart_pkg::addr_data, got);
            check_byte(got, sent[i], "byte before overflow");
        end
        host_read(uart_pkg::addr_data, got);
        check_byte(got, '0, "read after the discarded byte");
    endtask

    task automatic frame_error_in();
        logic [uart_pkg::data_w-1:0] b;
        logic [uart_pkg::data_w-1:0] got;
        uart_pkg::uart_status_t      st;
        b = 8'($random(seed));
        send_frame(b, 1'b1);
        read_status(st);
        check_status(st, make_status(1, 0, 0, 0, 0), "status after bad stop bit");
        b = 8'($random(seed));
        send_frame(b, 1'b0);
        wait_rx_avail(st);
        check_status(st, make_status(0, 0, 1, 0, 0), "status after good frame");
        host_read(uart_pkg::addr_data, got);
        check_byte(got, b, "byte after frame error");
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        req   = 1'b0;
        we    = 1'b0;
        addr  = uart_pkg::addr_data;
        wdata = '0;
        rx    = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        after_reset();
        single_byte_out();
        burst_out();
        bytes_in();
        overflow_in();
        frame_error_in();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
    parameter int depth = 16
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         wr_en,
    input  wire [uart_pkg::data_w-1:0]  wr_data,
    input  wire                         rd_en,
    output logic [uart_pkg::data_w-1:0] rd_data,
    output logic                        full,
    output logic                        empty
);

    localparam int addr_w = $clog2(depth);

    logic [uart_pkg::data_w-1:0] mem [depth];
    logic [addr_w:0]             wr_ptr;
    logic [addr_w:0]             rd_ptr;

    // the extra pointer bit tells a full buffer from an empty one.
    assign empty = wr_ptr == rd_ptr;
    assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                   (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

    assign rd_data = mem[rd_ptr[addr_w-1:0]];  // first-word fall-through.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && !full) begin
            mem[wr_ptr[addr_w-1:0]] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- src/uart_chan_if.sv
`timescale 1ns/1ns
`default_nettype none

interface tx_chan_if;

    logic                        push;
    logic [uart_pkg::data_w-1:0] data;
    logic                        full;
    logic                        busy;

    modport host (
        output push,
        output data,
        input  full,
        input  busy
    );

    modport path (
        input  push,
        input  data,
        output full,
        output busy
    );

endinterface

interface rx_chan_if;

    logic                        pop;
    logic [uart_pkg::data_w-1:0] data;   // head byte, valid while avail is high.
    logic                        avail;
    logic                        overflow;
    logic                        frame_err;
    logic                        clear_err;

    modport host (
        output pop,
        output clear_err,
        input  data,
        input  avail,
        input  overflow,
        input  frame_err
    );

    modport path (
        input  pop,
        input  clear_err,
        output data,
        output avail,
        output overflow,
        output frame_err
    );

endinterface

`default_nettype wire

//--- src/uart_core.sv
`timescale 1ns/1ns
`default_nettype none

module uart_core #(
    parameter int clks_per_bit = 868,
    parameter int fifo_depth   = 16
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         req,
    input  wire                         we,
    input  wire uart_pkg::reg_addr_e    addr,
    input  wire [uart_pkg::data_w-1:0]  wdata,
    output logic                        ack,
    output logic [uart_pkg::data_w-1:0] rdata,
    output logic                        tx,
    input  wire                         rx
);

    tx_chan_if tx_chan ();
    rx_chan_if rx_chan ();

    uart_host_regs host_regs_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .we     (we),
        .addr   (addr),
        .wdata  (wdata),
        .ack    (ack),
        .rdata  (rdata),
        .tx_chan(tx_chan.host),
        .rx_chan(rx_chan.host)
    );

    uart_tx_path #(
        .clks_per_bit(clks_per_bit),
        .fifo_depth  (fifo_depth)
    ) tx_path_i (
        .clk  (clk),
        .rst_n(rst_n),
        .chan (tx_chan.path),
        .tx   (tx)
    );

    uart_rx_path #(
        .clks_per_bit(clks_per_bit),
        .fifo_depth  (fifo_depth)
    ) rx_path_i (
        .clk  (clk),
        .rst_n(rst_n),
        .rx   (rx),
        .chan (rx_chan.path)
    );

endmodule

`default_nettype wire

//--- src/uart_host_regs.sv
`timescale 1ns/1ns
`default_nettype none

module uart_host_regs (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         req,
    input  wire                         we,
    input  wire uart_pkg::reg_addr_e    addr,
    input  wire [uart_pkg::data_w-1:0]  wdata,
    output logic                        ack,
    output logic [uart_pkg::data_w-1:0] rdata,
    tx_chan_if.host                     tx_chan,
    rx_chan_if.host                     rx_chan
);

    typedef enum logic [1:0] {
        hs_idle = 2'd0,
        hs_act  = 2'd1,
        hs_ack  = 2'd2
    } hs_state_e;

    hs_state_e              state;
    uart_pkg::uart_status_t status;
    logic                   act;
    logic                   data_sel;

    assign act      = state == hs_act;
    assign data_sel = addr == uart_pkg::addr_data;

    // both paths meet here in one status word.
    assign status.frame_err   = rx_chan.frame_err;
    assign status.rx_overflow = rx_chan.overflow;
    assign status.rx_avail    = rx_chan.avail;
    assign status.tx_full     = tx_chan.full;
    assign status.tx_busy     = tx_chan.busy;

    // act lasts one cycle, so every strobe fires once per access.
    assign tx_chan.push      = act && we && data_sel;
    assign tx_chan.data      = wdata;
    assign rx_chan.pop       = act && !we && data_sel && rx_chan.avail;
    assign rx_chan.clear_err = act && !we && !data_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= hs_idle;
            ack   <= 1'b0;
            rdata <= '0;
        end else begin
            case (state)
                hs_idle: begin
                    if (req) begin
                        state <= hs_act;
                    end
                end
                hs_act: begin
                    state <= hs_ack;
                    if (we) begin
                        rdata <= '0;
                    end else if (!data_sel) begin
                        rdata <= uart_pkg::data_w'(status);
                    end else if (rx_chan.avail) begin
                        rdata <= rx_chan.data;  // head byte, taken as it is popped.
                    end else begin
                        rdata <= '0;
                    end
                end
                default: begin
                    if (req) begin
                        ack <= 1'b1;
                    end else begin
                        ack   <= 1'b0;
                        state <= hs_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/uart_pkg.sv
`default_nettype none

package uart_pkg;

    localparam int data_w = 8;

    // one bit of address selects between the two host registers
    typedef enum logic [0:0] {
        addr_data   = 1'b0,
        addr_status = 1'b1
    } reg_addr_e;

    typedef enum logic [1:0] {
        tx_idle  = 2'd0,
        tx_start = 2'd1,
        tx_data  = 2'd2,
        tx_stop  = 2'd3
    } tx_state_e;

    typedef enum logic [1:0] {
        rx_idle  = 2'd0,
        rx_start = 2'd1,
        rx_data  = 2'd2,
        rx_stop  = 2'd3
    } rx_state_e;

    typedef struct packed {
        logic frame_err;    // sticky until a status read.
        logic rx_overflow;  // sticky until a status read.
        logic rx_avail;
        logic tx_full;
        logic tx_busy;
    } uart_status_t;

endpackage

`default_nettype wire

//--- src/uart_rx_path.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx_path #(
    parameter int clks_per_bit = 868,
    parameter int fifo_depth   = 16
) (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       rx,
    rx_chan_if.path   chan
);

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam int idx_w = $clog2(uart_pkg::data_w);

    uart_pkg::rx_state_e         state;
    logic                        rx_meta;
    logic                        rx_sync;
    logic                        rx_prev;
    logic [cnt_w-1:0]            bit_cnt;
    logic [idx_w-1:0]            bit_idx;
    logic [uart_pkg::data_w-1:0] shift;
    logic                        fifo_full;
    logic                        fifo_empty;
    logic                        bit_done;
    logic                        half_done;
    logic                        stop_sample;
    logic                        wr_en;

    assign bit_done    = bit_cnt == cnt_w'(clks_per_bit - 1);
    assign half_done   = bit_cnt == cnt_w'(clks_per_bit / 2 - 1);
    assign stop_sample = state == uart_pkg::rx_stop && bit_done;
    assign wr_en       = stop_sample && rx_sync && !fifo_full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= uart_pkg::rx_idle;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                uart_pkg::rx_idle: begin
                    bit_cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= uart_pkg::rx_start;
                    end
                end
                uart_pkg::rx_start: begin
                    if (half_done) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        // a line that is high again at mid-start was a glitch.
                        state   <= rx_sync ? uart_pkg::rx_idle : uart_pkg::rx_data;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                uart_pkg::rx_data: begin
                    if (bit_done) begin
                        bit_cnt <= '0;
                        if (bit_idx == idx_w'(uart_pkg::data_w - 1)) begin
                            state <= uart_pkg::rx_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_done) begin
                        state   <= uart_pkg::rx_idle;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == uart_pkg::rx_data && bit_done) begin
            shift <= {rx_sync, shift[uart_pkg::data_w-1:1]};  // lsb arrives first.
        end
    end

    // a new error wins over a clear in the same cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chan.overflow  <= 1'b0;
            chan.frame_err <= 1'b0;
        end else begin
            if (stop_sample && rx_sync && fifo_full) begin
                chan.overflow <= 1'b1;
            end else if (chan.clear_err) begin
                chan.overflow <= 1'b0;
            end
            if (stop_sample && !rx_sync) begin
                chan.frame_err <= 1'b1;
            end else if (chan.clear_err) begin
                chan.frame_err <= 1'b0;
            end
        end
    end

    sync_fifo #(
        .depth(fifo_depth)
    ) fifo_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (wr_en),
        .wr_data(shift),
        .rd_en  (chan.pop),
        .rd_data(chan.data),
        .full   (fifo_full),
        .empty  (fifo_empty)
    );

    assign chan.avail = !fifo_empty;

endmodule

`default_nettype wire

//--- src/uart_tx_path.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx_path #(
    parameter int clks_per_bit = 868,
    parameter int fifo_depth   = 16
) (
    input  wire       clk,
    input  wire       rst_n,
    tx_chan_if.path   chan,
    output logic      tx
);

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam int idx_w = $clog2(uart_pkg::data_w);

    uart_pkg::tx_state_e         state;
    logic [cnt_w-1:0]            bit_cnt;
    logic [idx_w-1:0]            bit_idx;
    logic [uart_pkg::data_w-1:0] shift;
    logic [uart_pkg::data_w-1:0] head;
    logic                        fifo_empty;
    logic                        bit_done;
    logic                        load;

    assign bit_done = bit_cnt == cnt_w'(clks_per_bit - 1);

    // a new byte is taken from idle, or straight out of the stop bit.
    assign load = !fifo_empty &&
                  (state == uart_pkg::tx_idle || (state == uart_pkg::tx_stop && bit_done));

    sync_fifo #(
        .depth(fifo_depth)
    ) fifo_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (chan.push),
        .wr_data(chan.data),
        .rd_en  (load),
        .rd_data(head),
        .full   (chan.full),
        .empty  (fifo_empty)
    );

    assign chan.busy = !fifo_empty || state != uart_pkg::tx_idle;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= uart_pkg::tx_idle;
            bit_cnt <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
        end else if (load) begin
            state   <= uart_pkg::tx_start;
            bit_cnt <= '0;
            tx      <= 1'b0;  // start bit.
        end else begin
            case (state)
                uart_pkg::tx_start: begin
                    if (bit_done) begin
                        state   <= uart_pkg::tx_data;
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        tx      <= shift[0];
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                uart_pkg::tx_data: begin
                    if (bit_done) begin
                        bit_cnt <= '0;
                        if (bit_idx == idx_w'(uart_pkg::data_w - 1)) begin
                            state <= uart_pkg::tx_stop;
                            tx    <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shift[0];
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                uart_pkg::tx_stop: begin
                    if (bit_done) begin
                        state   <= uart_pkg::tx_idle;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    tx <= 1'b1;
                end
            endcase
        end
    end

    // the next data bit always waits in shift[0].
    always_ff @(posedge clk) begin
        if (load) begin
            shift <= head;
        end else if (bit_done &&
                     (state == uart_pkg::tx_start || state == uart_pkg::tx_data)) begin
            shift <= {1'b0, shift[uart_pkg::data_w-1:1]};
        end
    end

endmodule

`default_nettype wire

//--- tb.f
src/uart_pkg.sv
src/uart_chan_if.sv
src/sync_fifo.sv
src/uart_tx_path.sv
src/uart_rx_path.sv
src/uart_host_regs.sv
src/uart_core.sv
bench/uart_core_checker.sv
bench/uart_core_tb.sv
